/* common/issue_settings.svh */
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// Slots handled per cycle by every stage
`define ISSUE_WIDTH 2

// Instruction buffer entries
`define BUF_DEPTH 8

// Architectural register file
`define NUM_REGS 16
`define REG_BITS 4   // Index width for NUM_REGS

// Register and result width
`define DATA_WIDTH 32

// Every count in the slice runs 0 to ISSUE_WIDTH
`define COUNT_BITS 2

`endif

/* common/issue_pkg.sv */
`include "issue_settings.svh"

package issue_pkg;

    // ALU operations, all register to register except the immediate forms
    typedef enum logic [2:0] {
        op_add  = 3'd0,  // rs1 + rs2
        op_sub  = 3'd1,  // rs1 - rs2
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_sll  = 3'd5,  // rs1 << rs2[4:0]
        op_addi = 3'd6,  // rs1 + sext(imm)
        op_li   = 3'd7   // sext(imm), no sources
    } op_e;

    // Instruction as written into the buffer
    typedef struct packed {
        op_e                  op;
        logic [`REG_BITS-1:0] rd;
        logic [`REG_BITS-1:0] rs1;
        logic [`REG_BITS-1:0] rs2;
        logic [7:0]           imm;   // Sign extended at decode
    } inst_t;

    // Decoded operation with its operands already read
    typedef struct packed {
        op_e                    op;
        logic [`REG_BITS-1:0]   rd;
        logic [`DATA_WIDTH-1:0] src1;
        logic [`DATA_WIDTH-1:0] src2;
        logic [`DATA_WIDTH-1:0] imm;
    } uop_t;

endpackage

/* inst_buffer/inst_buffer.sv */
`include "issue_settings.svh"

module inst_buffer (
    input  logic                                clock,
    input  logic                                reset,
    input  issue_pkg::inst_t [`ISSUE_WIDTH-1:0] in_insts,    // Oldest in slot 0
    input  logic             [`COUNT_BITS-1:0]  in_count,    // Count, not a mask
    input  logic             [`COUNT_BITS-1:0]  issue_count, // Entries leaving at the edge
    output issue_pkg::inst_t [`ISSUE_WIDTH-1:0] head_insts,
    output logic             [`COUNT_BITS-1:0]  head_count,
    output logic             [`COUNT_BITS-1:0]  spots
);
    import issue_pkg::*;

    localparam int PTR_BITS = $clog2(`BUF_DEPTH);
    localparam int OCC_BITS = $clog2(`BUF_DEPTH + 1);

    inst_t [`BUF_DEPTH-1:0] mem;

    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [OCC_BITS-1:0] occupancy;
    logic [OCC_BITS-1:0] free_entries;

    // Wrapping pointer step, safe for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] ptr_add(input logic [PTR_BITS-1:0] ptr,
                                                    input int step);
        int sum;
        sum = int'(ptr) + step;
        return PTR_BITS'(sum % `BUF_DEPTH);
    endfunction

    assign free_entries = OCC_BITS'(`BUF_DEPTH) - occupancy;

    always_comb begin
        // Both counts saturate at the slot width
        if (int'(free_entries) < `ISSUE_WIDTH) begin
            spots = `COUNT_BITS'(free_entries);
        end else begin
            spots = `COUNT_BITS'(`ISSUE_WIDTH);
        end
        if (int'(occupancy) < `ISSUE_WIDTH) begin
            head_count = `COUNT_BITS'(occupancy);
        end else begin
            head_count = `COUNT_BITS'(`ISSUE_WIDTH);
        end
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            head_insts[i] = mem[ptr_add(head, i)];  // Stale beyond head_count
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= ptr_add(head, int'(issue_count));
            tail      <= ptr_add(tail, int'(in_count));
            occupancy <= occupancy + OCC_BITS'(in_count) - OCC_BITS'(issue_count);
        end
    end

    // Entry storage
    always_ff @(posedge clock) begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (i < int'(in_count)) begin
                mem[ptr_add(tail, i)] <= in_insts[i];
            end
        end
    end

endmodule

/* src/decode_stage.sv */
`include "issue_settings.svh"

module decode_stage (
    input  logic                                               clock,
    input  logic                                               reset,
    input  issue_pkg::inst_t [`ISSUE_WIDTH-1:0]                head_insts,
    input  logic             [`COUNT_BITS-1:0]                 head_count,
    output logic             [`COUNT_BITS-1:0]                 issue_count,
    output logic             [`ISSUE_WIDTH-1:0][1:0][`REG_BITS-1:0]   rd_addr,
    input  logic             [`ISSUE_WIDTH-1:0][1:0][`DATA_WIDTH-1:0] rd_data,
    input  logic             [`NUM_REGS-1:0]                   free_mask,
    output logic             [`COUNT_BITS-1:0]                 exe_count,
    output issue_pkg::uop_t  [`ISSUE_WIDTH-1:0]                exe_uops
);
    import issue_pkg::*;

    logic [`NUM_REGS-1:0]    busy;         // Destinations still in flight
    logic [`NUM_REGS-1:0]    busy_next;
    logic [`NUM_REGS-1:0]    issued_mask;
    logic [`ISSUE_WIDTH-1:0] blocked;
    logic                    stop;
    uop_t [`ISSUE_WIDTH-1:0] uops;

    function automatic logic uses_rs1(input op_e op);
        return op != op_li;
    endfunction

    function automatic logic uses_rs2(input op_e op);
        return !(op inside {op_li, op_addi});
    endfunction

    // True if inst reads reg through one of its live sources
    function automatic logic reads_reg(input inst_t inst, input logic [`REG_BITS-1:0] reg_idx);
        return (uses_rs1(inst.op) && inst.rs1 == reg_idx) ||
               (uses_rs2(inst.op) && inst.rs2 == reg_idx);
    endfunction

    // Per slot hazard check
    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            blocked[i] = busy[head_insts[i].rd];
            if (uses_rs1(head_insts[i].op) && busy[head_insts[i].rs1]) begin
                blocked[i] = 1'b1;
            end
            if (uses_rs2(head_insts[i].op) && busy[head_insts[i].rs2]) begin
                blocked[i] = 1'b1;
            end
            // Older slots in the same group
            for (int j = 0; j < i; j++) begin
                if (head_insts[j].rd != '0) begin
                    if (head_insts[i].rd == head_insts[j].rd ||
                        reads_reg(head_insts[i], head_insts[j].rd)) begin
                        blocked[i] = 1'b1;
                    end
                end
            end
        end
    end

    // Longest in-order prefix that is present and free of hazards
    always_comb begin
        issue_count = '0;
        stop        = 1'b0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (i >= int'(head_count) || blocked[i]) begin
                stop = 1'b1;
            end
            if (!stop) begin
                issue_count = `COUNT_BITS'(i + 1);
            end
        end
    end

    // Operand read and uop build
    always_comb begin
        issued_mask = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            rd_addr[i][0] = head_insts[i].rs1;
            rd_addr[i][1] = head_insts[i].rs2;
            uops[i].op    = head_insts[i].op;
            uops[i].rd    = head_insts[i].rd;
            uops[i].src1  = rd_data[i][0];
            uops[i].src2  = rd_data[i][1];
            uops[i].imm   = `DATA_WIDTH'($signed(head_insts[i].imm));
            if (i < int'(issue_count)) begin
                issued_mask[head_insts[i].rd] = 1'b1;
            end
        end
        issued_mask[0] = 1'b0;  // r0 is never busy
        busy_next = (busy & ~free_mask) | issued_mask;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= '0;
            exe_count <= '0;
        end else begin
            busy      <= busy_next;
            exe_count <= issue_count;
        end
        exe_uops <= uops;  // Lanes past exe_count are don't care
    end

endmodule

/* src/execute_stage.sv */
`include "issue_settings.svh"

module execute_stage (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic            [`COUNT_BITS-1:0]             exe_count,
    input  issue_pkg::uop_t [`ISSUE_WIDTH-1:0]            exe_uops,
    output logic            [`COUNT_BITS-1:0]             wb_count,
    output logic            [`ISSUE_WIDTH-1:0][`REG_BITS-1:0]   wb_rd,
    output logic            [`ISSUE_WIDTH-1:0][`DATA_WIDTH-1:0] wb_value
);
    import issue_pkg::*;

    logic [`ISSUE_WIDTH-1:0][`DATA_WIDTH-1:0] alu_out;

    function automatic logic [`DATA_WIDTH-1:0] alu(input uop_t uop);
        logic [`DATA_WIDTH-1:0] result;
        case (uop.op)
            op_add:  result = uop.src1 + uop.src2;
            op_sub:  result = uop.src1 - uop.src2;
            op_and:  result = uop.src1 & uop.src2;
            op_or:   result = uop.src1 | uop.src2;
            op_xor:  result = uop.src1 ^ uop.src2;
            op_sll:  result = uop.src1 << uop.src2[4:0];  // Low 5 bits only
            op_addi: result = uop.src1 + uop.imm;
            op_li:   result = uop.imm;
            default: result = '0;
        endcase
        return result;
    endfunction

    // One ALU per lane
    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            alu_out[i] = alu(exe_uops[i]);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_count <= '0;
        end else begin
            wb_count <= exe_count;
        end
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            wb_rd[i]    <= exe_uops[i].rd;
            wb_value[i] <= alu_out[i];
        end
    end

endmodule

/* src/result_stage.sv */
`include "issue_settings.svh"

module result_stage (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic [`COUNT_BITS-1:0]                        wb_count,
    input  logic [`ISSUE_WIDTH-1:0][`REG_BITS-1:0]        wb_rd,
    input  logic [`ISSUE_WIDTH-1:0][`DATA_WIDTH-1:0]      wb_value,
    input  logic [`ISSUE_WIDTH-1:0][1:0][`REG_BITS-1:0]   rd_addr,
    output logic [`ISSUE_WIDTH-1:0][1:0][`DATA_WIDTH-1:0] rd_data,
    output logic [`NUM_REGS-1:0]                          free_mask,
    output logic [`COUNT_BITS-1:0]                        ret_count,
    output logic [`ISSUE_WIDTH-1:0][`REG_BITS-1:0]        ret_rd,
    output logic [`ISSUE_WIDTH-1:0][`DATA_WIDTH-1:0]      ret_value
);

    logic [`NUM_REGS-1:0][`DATA_WIDTH-1:0] regs;

    // Combinational read ports, two per slot
    always_comb begin
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            for (int k = 0; k < 2; k++) begin
                if (rd_addr[i][k] == '0) begin
                    rd_data[i][k] = '0;
                end else begin
                    rd_data[i][k] = regs[rd_addr[i][k]];
                end
            end
        end
    end

    // Registers written at the coming edge
    always_comb begin
        free_mask = '0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            if (i < int'(wb_count)) begin
                free_mask[wb_rd[i]] = 1'b1;
            end
        end
        free_mask[0] = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            regs      <= '0;
            ret_count <= '0;
        end else begin
            // Later lane wins on a shared destination
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                if (i < int'(wb_count) && wb_rd[i] != '0) begin
                    regs[wb_rd[i]] <= wb_value[i];
                end
            end
            ret_count <= wb_count;
        end
        ret_rd    <= wb_rd;
        ret_value <= wb_value;  // r0 writes still report their value
    end

endmodule

/* src/issue_top.sv */
`include "issue_settings.svh"

module issue_top (
    input  logic                                     clock,
    input  logic                                     reset,
    input  issue_pkg::inst_t [`ISSUE_WIDTH-1:0]      in_insts,
    input  logic [`COUNT_BITS-1:0]                   in_count,
    output logic [`COUNT_BITS-1:0]                   spots,
    output logic [`COUNT_BITS-1:0]                   ret_count,
    output logic [`ISSUE_WIDTH-1:0][`REG_BITS-1:0]   ret_rd,
    output logic [`ISSUE_WIDTH-1:0][`DATA_WIDTH-1:0] ret_value
);
    import issue_pkg::*;

    // Buffer to decode
    inst_t [`ISSUE_WIDTH-1:0] head_insts;
    logic  [`COUNT_BITS-1:0]  head_count;
    logic  [`COUNT_BITS-1:0]  issue_count;

    // Register file read ports
    logic [`ISSUE_WIDTH-1:0][1:0][`REG_BITS-1:0]   rd_addr;
    logic [`ISSUE_WIDTH-1:0][1:0][`DATA_WIDTH-1:0] rd_data;
    logic [`NUM_REGS-1:0]                          free_mask;

    // Decode to execute to write-back
    logic [`COUNT_BITS-1:0]                   exe_count;
    uop_t [`ISSUE_WIDTH-1:0]                  exe_uops;
    logic [`COUNT_BITS-1:0]                   wb_count;
    logic [`ISSUE_WIDTH-1:0][`REG_BITS-1:0]   wb_rd;
    logic [`ISSUE_WIDTH-1:0][`DATA_WIDTH-1:0] wb_value;

    inst_buffer inst_buffer_i (
        .clock, .reset,
        .in_insts, .in_count, .issue_count,
        .head_insts, .head_count, .spots
    );

    decode_stage decode_stage_i (
        .clock, .reset,
        .head_insts, .head_count, .issue_count,
        .rd_addr, .rd_data, .free_mask,
        .exe_count, .exe_uops
    );

    execute_stage execute_stage_i (
        .clock, .reset,
        .exe_count, .exe_uops,
        .wb_count, .wb_rd, .wb_value
    );

    result_stage result_stage_i (
        .clock, .reset,
        .wb_count, .wb_rd, .wb_value,
        .rd_addr, .rd_data, .free_mask,
        .ret_count, .ret_rd, .ret_value
    );

endmodule

/* dv/issue_tb.sv */
`include "issue_settings.svh"

module issue_tb;
    import issue_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;  // Roughly four times the random stream
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                                     clock;
    logic                                     reset;
    inst_t [`ISSUE_WIDTH-1:0]                 in_insts;
    logic [`COUNT_BITS-1:0]                   in_count;
    logic [`COUNT_BITS-1:0]                   spots;
    logic [`COUNT_BITS-1:0]                   ret_count;
    logic [`ISSUE_WIDTH-1:0][`REG_BITS-1:0]   ret_rd;
    logic [`ISSUE_WIDTH-1:0][`DATA_WIDTH-1:0] ret_value;

    // Reference state
    logic [`DATA_WIDTH-1:0] model_regs [`NUM_REGS];
    logic [`REG_BITS-1:0]   exp_rd [$];      // Program order
    logic [`DATA_WIDTH-1:0] exp_value [$];
    int                     sent_total = 0;
    int                     retired_total = 0;
    int                     cycle_count = 0;
    logic [`COUNT_BITS-1:0] min_spots = `COUNT_BITS'(`ISSUE_WIDTH);
    logic [31:0]            lfsr_state = 32'hc76aa17b;

    // Spots and accepted totals of the last two cycles
    int                     old_accepted [2];  // Index 1 holds the older sample
    logic [`COUNT_BITS-1:0] old_spots [2];
    int                     spots_samples = 0;

    issue_top issue_top_i (
        .clock, .reset,
        .in_insts, .in_count, .spots,
        .ret_count, .ret_rd, .ret_value
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_on_failure($sformatf("Fail at time %0t: %s, got %h, expected %h",
                                      $time, what, actual, expected));
        end
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_failure($sformatf("Timeout: the run did not end within %0d cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic inst_t make_inst(input op_e op, input int rd, input int rs1,
                                        input int rs2, input int imm);
        inst_t inst;
        inst.op  = op;
        inst.rd  = `REG_BITS'(rd);
        inst.rs1 = `REG_BITS'(rs1);
        inst.rs2 = `REG_BITS'(rs2);
        inst.imm = 8'(imm);
        return inst;
    endfunction

    function automatic inst_t random_inst();
        inst_t inst;
        inst.op  = op_e'(3'(random_bits(3)));
        inst.rd  = `REG_BITS'(random_bits(`REG_BITS));
        inst.rs1 = `REG_BITS'(random_bits(`REG_BITS));
        inst.rs2 = `REG_BITS'(random_bits(`REG_BITS));
        inst.imm = 8'(random_bits(8));
        return inst;
    endfunction

    // Result of one instruction against the model register file
    function automatic logic [`DATA_WIDTH-1:0] model_result(input inst_t inst);
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        logic [`DATA_WIDTH-1:0] imm;
        a   = model_regs[inst.rs1];
        b   = model_regs[inst.rs2];
        imm = {{(`DATA_WIDTH-8){inst.imm[7]}}, inst.imm};
        case (inst.op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_addi: return a + imm;
            default: return imm;  // op_li
        endcase
    endfunction

    task automatic apply_model(input inst_t inst);
        logic [`DATA_WIDTH-1:0] value;
        value = model_result(inst);
        exp_rd.push_back(inst.rd);
        exp_value.push_back(value);
        if (inst.rd != '0) begin
            model_regs[inst.rd] = value;  // r0 stays zero
        end
    endtask

    // A group issued at an edge shows on the retire ports two edges later
    // so the occupancy of two cycles back is its accepted total minus the retired total
    task automatic check_spots();
        int accepted;
        int free_space;
        accepted = sent_total - int'(in_count);  // The driven group enters at the next edge
        check_value(32'(spots <= `ISSUE_WIDTH), 32'd1, "spots above issue width");
        if (spots < min_spots) begin
            min_spots = spots;
        end
        if (spots_samples >= 2) begin
            free_space = `BUF_DEPTH - (old_accepted[1] - retired_total);
            check_value(32'(int'(old_spots[1]) <= free_space), 32'd1,
                        "spots above free buffer space");
        end
        old_accepted[1] = old_accepted[0];
        old_spots[1]    = old_spots[0];
        old_accepted[0] = accepted;
        old_spots[0]    = spots;
        spots_samples++;
    endtask

    // Entered and left 1 time unit after a rising edge
    task automatic send_group(input inst_t first, input inst_t second, input int n);
        while (int'(spots) < n) begin
            @(posedge clock);
            #1;
        end
        in_insts[0] = first;
        in_insts[1] = second;
        in_count    = `COUNT_BITS'(n);
        if (n > 0) begin
            apply_model(first);
        end
        if (n > 1) begin
            apply_model(second);
        end
        sent_total += n;
        @(posedge clock);
        #1;
        in_count = '0;
    endtask

    task automatic wait_for_retire();
        while (exp_rd.size() > 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    // Retire monitor with slot 0 as the oldest
    always @(negedge clock) begin
        logic [`REG_BITS-1:0]   rd;
        logic [`DATA_WIDTH-1:0] value;
        if (!reset) begin
            for (int i = 0; i < int'(ret_count); i++) begin
                if (exp_rd.size() == 0) begin
                    stop_on_failure("The DUT retired a result that was never sent");
                end
                rd    = exp_rd.pop_front();
                value = exp_value.pop_front();
                check_value(32'(ret_rd[i]), 32'(rd), "retired destination");
                check_value(ret_value[i], value, "retired value");
            end
            retired_total += int'(ret_count);
            check_spots();
        end
    end

    task automatic check_after_reset();
        check_value(32'(spots), `ISSUE_WIDTH, "spots after reset");
        check_value(32'(ret_count), 0, "ret_count after reset");
        send_group(make_inst(op_addi, 1, 0, 0, 5), make_inst(op_addi, 2, 0, 0, -3), 2);
        wait_for_retire();
    endtask

    task automatic independent_pairs();
        send_group(make_inst(op_li, 3, 0, 0, 8'h55), make_inst(op_li, 4, 0, 0, 8'ha3), 2);
        send_group(make_inst(op_add, 5, 3, 4, 0), make_inst(op_sub, 6, 3, 4, 0), 2);
        send_group(make_inst(op_and, 7, 3, 4, 0), make_inst(op_or, 8, 3, 4, 0), 2);
        send_group(make_inst(op_xor, 9, 3, 4, 0), make_inst(op_sll, 10, 3, 4, 0), 2);
        send_group(make_inst(op_li, 0, 0, 0, 8'h12), make_inst(op_li, 13, 0, 0, 9), 2);
        send_group(make_inst(op_addi, 11, 0, 0, 7), make_inst(op_add, 12, 0, 3, 0), 2);
        wait_for_retire();
    endtask

    task automatic dependency_chain();
        send_group(make_inst(op_li, 1, 0, 0, 1), make_inst(op_addi, 2, 1, 0, 1), 2);
        send_group(make_inst(op_add, 3, 2, 1, 0), make_inst(op_sub, 4, 3, 2, 0), 2);
        send_group(make_inst(op_sll, 5, 4, 1, 0), make_inst(op_xor, 1, 5, 3, 0), 2);
        send_group(make_inst(op_or, 2, 1, 5, 0), '0, 1);
        wait_for_retire();
    endtask

    task automatic fill_buffer_under_stall();
        int sent;
        int n;
        sent      = 0;
        min_spots = `COUNT_BITS'(`ISSUE_WIDTH);
        send_group(make_inst(op_li, 6, 0, 0, 3), '0, 1);
        while (sent < 24) begin
            n = int'(spots);  // Take whatever room is left even when it is zero
            if (n > 24 - sent) begin
                n = 24 - sent;
            end
            send_group(make_inst(op_addi, 6, 6, 0, 1), make_inst(op_addi, 6, 6, 0, 1), n);
            sent += n;
        end
        check_value(32'(min_spots), 0, "spots never reached zero while decode stalled");
        wait_for_retire();
    endtask

    task automatic random_stream();
        int sent;
        int n;
        inst_t first;
        inst_t second;
        sent = 0;
        while (sent < 300) begin
            n = int'(random_bits(2) % 3);
            if (n > 300 - sent) begin
                n = 300 - sent;
            end
            first  = random_inst();
            second = random_inst();
            send_group(first, second, n);
            sent += n;
        end
        wait_for_retire();
    endtask

    initial begin
        reset    = 1'b1;
        in_insts = '0;
        in_count = '0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        check_after_reset();
        independent_pairs();
        dependency_chain();
        fill_buffer_under_stall();
        random_stream();

        check_value(32'(retired_total), 32'(sent_total), "retired count against sent count");
        $display("Everything OK");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+common
common/issue_pkg.sv
inst_buffer/inst_buffer.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/issue_top.sv
dv/issue_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the issue slice testbench with Verilator and runs it.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator was not found on PATH"
    exit 1
fi

if ! verilator --binary -f verilog.f --top-module issue_tb -Mdir obj_dir -o issue_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/issue_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit "$status"
fi

exit 0
